// File: bench/bus_interface_props.sv
/*
 * Bus interface protocol checker
 * Concurrent assertions on the top-level ports of the bus interface,
 * bound into every instance of it
 */
`timescale 1ns/1ns
`default_nettype none

module bus_interface_props import biu_pkg::*;
(
   input  wire         clk,
   input  wire         resetn,
   input  bus_req_t    req,
   input  data_t       data_in,
   input  wire         dtackn,
   input  wire         berrn,
   input  wire         bgackn,
   input  bus_strobe_t strobes,
   input  wire         bus_en,
   input  wire         adr_en,
   input  wire         hi_byte_en,
   input  wire         lo_byte_en,
   input  wire         bus_cyc_rdy,
   input  wire         bus_err,
   input  data_t       data_core_out,
   input  wire         bgn
);

   int    fail_cnt = 0;
   logic  in_cycle;
   logic  ds_seen;
   logic  dtack_seen;
   logic  berr_low;
   data_t dtack_data;
   logic  want_hi;
   logic  want_lo;
   logic  ds_low;

   // Lanes the current request should use, word on both
   assign want_hi = req.byten_word ? 1'b1 : (req.a0 == 1'b0);
   assign want_lo = req.byten_word ? 1'b1 : (req.a0 == 1'b1);
   assign ds_low  = ~(strobes.udsn & strobes.ldsn);

   task automatic flag_error(input string msg);
      fail_cnt++;
      $error("ERR %0t %s", $time, msg);
   endtask

   // ----------------------------------------------------------------------
   // Cycle tracking from asn low to ready
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge resetn)
   begin
      if (~resetn)
      begin
         in_cycle   <= 1'b0;
         ds_seen    <= 1'b0;
         dtack_seen <= 1'b0;
         berr_low   <= 1'b0;
         dtack_data <= '0;
      end
      else if (bus_cyc_rdy)
      begin
         in_cycle   <= 1'b0;
         ds_seen    <= 1'b0;
         dtack_seen <= 1'b0;
         berr_low   <= 1'b0;
      end
      else if (~strobes.asn)
      begin
         in_cycle <= 1'b1;
         if (ds_low)
            ds_seen <= 1'b1;
         if (~berrn)
            berr_low <= 1'b1;
         // Word on the bus at the first acknowledge
         if (~dtackn & ~dtack_seen)
         begin
            dtack_seen <= 1'b1;
            dtack_data <= data_in;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Bus cycle
   // ----------------------------------------------------------------------
   assert property (@(posedge clk) disable iff (~resetn)
                    bus_cyc_rdy |-> in_cycle && ds_seen)
      else flag_error("bus_cyc_rdy without asn and a data strobe");
   // asn released only when the cycle ends
   assert property (@(posedge clk) disable iff (~resetn) $rose(strobes.asn) |-> bus_cyc_rdy)
      else flag_error("asn rose before bus_cyc_rdy");
   // No bus error means the slave must have acknowledged
   assert property (@(posedge clk) disable iff (~resetn)
                    bus_cyc_rdy && !bus_err |-> dtack_seen)
      else flag_error("cycle ended without dtackn or bus error");
   assert property (@(posedge clk) disable iff (~resetn)
                    bus_cyc_rdy && strobes.rwn && !bus_err |-> data_core_out == dtack_data)
      else flag_error("read word differs from the acknowledged data");
   assert property (@(posedge clk) disable iff (~resetn)
                    bus_err |-> berr_low && $stable(data_core_out))
      else flag_error("bus error without berrn or with new read data");

   // ----------------------------------------------------------------------
   // Lanes and direction
   // ----------------------------------------------------------------------
   assert property (@(posedge clk) disable iff (~resetn) ds_low |->
                    (!strobes.udsn == want_hi) && (!strobes.ldsn == want_lo) &&
                    (!strobes.rwn == req.wr_bus))
      else flag_error("data strobes break the lane rule or direction");
   assert property (@(posedge clk) disable iff (~resetn) hi_byte_en || lo_byte_en |->
                    !strobes.rwn && (hi_byte_en == want_hi) && (lo_byte_en == want_lo))
      else flag_error("byte lane enables wrong");
   // Write data must be on its lanes while the slave strobes it in
   assert property (@(posedge clk) disable iff (~resetn) ds_low && !strobes.rwn |->
                    (hi_byte_en == want_hi) && (lo_byte_en == want_lo))
      else flag_error("byte lane drivers off during a write strobe");

   // ----------------------------------------------------------------------
   // Arbitration
   // ----------------------------------------------------------------------
   assert property (@(posedge clk) disable iff (~resetn)
                    ds_low || !strobes.asn |-> bus_en && adr_en)
      else flag_error("strobe active with drivers off");
   assert property (@(posedge clk) disable iff (~resetn) !bgn || !bgackn |-> !bus_en && !adr_en)
      else flag_error("drivers on while bus is granted away");
   assert property (@(posedge clk) disable iff (~resetn) $fell(bgn) |-> strobes.asn)
      else flag_error("bus granted during a cycle");

endmodule

bind bus_interface bus_interface_props props_i (.*);

`default_nettype wire

// File: bench/bus_interface_tb.sv
/*
 * Testbench for the bus interface unit
 * Reads, writes, wait states, a bus error and 2/3-wire arbitration,
 * checked by the bound protocol assertions
 */
`timescale 1ns/1ns
`default_nettype none

module bus_interface_tb import biu_pkg::*;
();

   logic        clk = 1'b0;
   logic        resetn;
   bus_req_t    req;
   data_t       data_in;
   logic        dtackn;
   logic        berrn;
   logic        brn;
   logic        bgackn;
   bus_strobe_t strobes;
   logic        bus_en;
   logic        adr_en;
   logic        hi_byte_en;
   logic        lo_byte_en;
   logic        bus_cyc_rdy;
   logic        bus_err;
   data_t       data_core_out;
   logic        bgn;

   int          seed = 86207;
   logic [31:0] rnd;
   // Per-cycle slave answer, set by the core side before each request
   logic [1:0]  ack_delay;
   data_t       cyc_data;
   logic        berr_mode;
   logic [1:0]  waited;

   bus_interface dut_i (.*);

   initial
   begin
      forever #4 clk = ~clk;
   end

   task automatic fail_now(input string why);
      $display("%s at %0t", why, $time);
      $display("Something failed");
      $fatal(1, "Simulation stopped");
   endtask

   // Any failed assertion in the checker ends the run
   always @(negedge clk)
   begin
      if (dut_i.props_i.fail_cnt != 0)
         fail_now("A bus protocol assertion failed");
   end

   // ----------------------------------------------------------------------
   // Slave model, dtackn after a random delay once asn is low
   // ----------------------------------------------------------------------
   initial
   begin
      dtackn  = 1'b1;
      data_in = '0;
      waited  = 2'd0;
      forever
      begin
         @(negedge clk);
         if (strobes.asn)
         begin
            dtackn = 1'b1;
            waited = 2'd0;
         end
         else if (berr_mode)
            // No acknowledge, only junk on the data lines
            data_in = ~cyc_data;
         else if (waited == ack_delay)
         begin
            // Valid word together with the acknowledge
            data_in = cyc_data;
            dtackn  = 1'b0;
         end
         else
         begin
            data_in = ~cyc_data;
            waited  = waited + 2'd1;
         end
      end
   end

   task automatic wait_ready();
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
         if (n > 64)
            fail_now("Timeout waiting for bus_cyc_rdy");
      end
      while (!bus_cyc_rdy);
   endtask

   task automatic wait_grant();
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
         if (n > 64)
            fail_now("Timeout waiting for bgn");
      end
      while (bgn);
   endtask

   // Core request with a fresh slave delay and read word
   task automatic post_request(input logic is_write, input logic a0, input logic word);
      rnd            = $random(seed);
      ack_delay      = rnd[1:0];
      cyc_data       = rnd[31:16];
      req.rd_bus     = ~is_write;
      req.wr_bus     = is_write;
      req.a0         = a0;
      req.byten_word = word;
   endtask

   // Request held through the ready slice, then one idle slice
   task automatic finish_request();
      wait_ready();
      @(negedge clk);
      req = '0;
      @(negedge clk);
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      resetn    = 1'b0;
      req       = '0;
      berrn     = 1'b1;
      brn       = 1'b1;
      bgackn    = 1'b1;
      berr_mode = 1'b0;
      ack_delay = 2'd0;
      cyc_data  = '0;
      repeat (2) @(negedge clk);
      resetn = 1'b1;
      @(negedge clk);

      // Reads and writes, random lanes and wait states
      repeat (16)
      begin
         rnd = $random(seed);
         post_request(rnd[2], rnd[0], rnd[1]);
         finish_request();
      end

      // Bus error, slave never acknowledges
      berr_mode = 1'b1;
      berrn     = 1'b0;
      post_request(1'b0, 1'b0, 1'b1);
      finish_request();
      berrn     = 1'b1;
      berr_mode = 1'b0;

      // 2-wire, read pending until brn goes away
      brn = 1'b0;
      wait_grant();
      post_request(1'b0, 1'b1, 1'b0);
      repeat (3) @(negedge clk);
      brn = 1'b1;
      finish_request();

      // 3-wire, next master already waiting at hand-back
      brn = 1'b0;
      wait_grant();
      bgackn = 1'b0;
      brn    = 1'b1;
      post_request(1'b1, 1'b0, 1'b1);
      repeat (3) @(negedge clk);
      brn = 1'b0;
      @(negedge clk);
      bgackn = 1'b1;
      wait_grant();
      brn = 1'b1;
      finish_request();

      repeat (4) @(negedge clk);
      if (dut_i.props_i.fail_cnt != 0)
         fail_now("A bus protocol assertion failed");
      else
      begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: common/biu_pkg.sv
/*
 * Bus interface unit shared types
 * Slice and arbiter state encodings, the data word, the core request
 * and bus strobe bundles, and the slice windows of the bus strobes
 */
`default_nettype none

package biu_pkg;

   localparam int DATA_W = 16;

   // Data bus word
   typedef logic [DATA_W-1:0] data_t;

   // Bus time slices, one clock each
   typedef enum logic [2:0] {S0, S1, S2, S3, S4, S5, S6, S7} slice_t;

   // Bus arbitration states
   typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_WAIT_RELEASE} arb_state_t;

   // Request from the core, held as a level until the cycle ends
   typedef struct packed {
      logic rd_bus;
      logic wr_bus;
      logic a0;
      logic byten_word;
   } bus_req_t;

   // Active-low bus control lines
   typedef struct packed {
      logic asn;
      logic udsn;
      logic ldsn;
      logic rwn;
   } bus_strobe_t;

   // --------------------------------------------------------------------
   // Strobe windows, first and last slice inclusive
   // --------------------------------------------------------------------
   localparam slice_t AS_FIRST    = S2;
   localparam slice_t AS_LAST     = S6;
   localparam slice_t RD_DS_FIRST = S2;
   localparam slice_t RD_DS_LAST  = S6;
   // Write data strobes wait until the data lines have settled
   localparam slice_t WR_DS_FIRST = S4;
   localparam slice_t WR_DS_LAST  = S6;
   localparam slice_t RW_FIRST    = S1;
   localparam slice_t RW_LAST     = S7;
   localparam slice_t ADR_FIRST   = S1;
   localparam slice_t ADR_LAST    = S7;
   localparam slice_t LANE_FIRST  = S3;
   localparam slice_t LANE_LAST   = S7;
   // Read word is sampled leaving S6, ready is shown in S7
   localparam slice_t CAP_SLICE   = S6;
   localparam slice_t RDY_SLICE   = S7;

endpackage

`default_nettype wire

// File: design/bus_arbiter.sv
/*
 * Bus arbiter
 * Hands the bus to an external master between bus cycles only.
 * Supports 2-wire release by brn and 3-wire hand-over by bgackn
 */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import biu_pkg::*;
(
   input  wire        clk,
   input  wire        resetn,
   input  slice_t     slice,
   input  wire        brn,
   input  wire        bgackn,
   output arb_state_t arb_state,
   output logic       bgn
);

   arb_state_t arb_next;

   // --------------------------------------------------------------------
   // Arbitration FSM
   // --------------------------------------------------------------------
   always_comb
   begin
      arb_next = arb_state;
      case (arb_state)
         ARB_IDLE:
            // Grant only outside a bus cycle
            if (~brn && (slice == S0))
               arb_next = ARB_GRANT;
         ARB_GRANT:
            if (~bgackn)
               arb_next = ARB_WAIT_RELEASE;
            else if (brn)
               // 2-wire release
               arb_next = ARB_IDLE;
         ARB_WAIT_RELEASE:
            if (bgackn)
            begin
               // Another master already waiting takes the bus next
               if (~brn)
                  arb_next = ARB_GRANT;
               else
                  arb_next = ARB_IDLE;
            end
         default:
            arb_next = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (~resetn)
         arb_state <= ARB_IDLE;
      else
         arb_state <= arb_next;
   end

   // Grant shown only while waiting for the acknowledge
   assign bgn = (arb_state != ARB_GRANT);

endmodule

`default_nettype wire

// File: design/bus_interface.sv
/*
 * Bus interface unit, top level
 * 68000-style read and write bus cycles with wait states, bus
 * error reporting and 2/3-wire bus arbitration
 */
`timescale 1ns/1ns
`default_nettype none

module bus_interface import biu_pkg::*;
(
   input  wire         clk,
   input  wire         resetn,
   input  bus_req_t    req,
   input  data_t       data_in,
   input  wire         dtackn,
   input  wire         berrn,
   input  wire         brn,
   input  wire         bgackn,
   output bus_strobe_t strobes,
   output logic        bus_en,
   output logic        adr_en,
   output logic        hi_byte_en,
   output logic        lo_byte_en,
   output logic        bus_cyc_rdy,
   output logic        bus_err,
   output data_t       data_core_out,
   output logic        bgn
);

   slice_t     slice;
   logic       berr_seen;
   arb_state_t arb_state;

   // Slice timing of the bus cycle
   cycle_timer timer_i (
      .clk       (clk),
      .resetn    (resetn),
      .req       (req),
      .arb_state (arb_state),
      .dtackn    (dtackn),
      .berrn     (berrn),
      .slice     (slice),
      .berr_seen (berr_seen)
   );

   // Bus ownership
   bus_arbiter arbiter_i (
      .clk       (clk),
      .resetn    (resetn),
      .slice     (slice),
      .brn       (brn),
      .bgackn    (bgackn),
      .arb_state (arb_state),
      .bgn       (bgn)
   );

   // Bus control outputs and read data
   strobe_decoder decoder_i (
      .clk           (clk),
      .resetn        (resetn),
      .slice         (slice),
      .arb_state     (arb_state),
      .berr_seen     (berr_seen),
      .req           (req),
      .data_in       (data_in),
      .strobes       (strobes),
      .bus_en        (bus_en),
      .adr_en        (adr_en),
      .hi_byte_en    (hi_byte_en),
      .lo_byte_en    (lo_byte_en),
      .bus_cyc_rdy   (bus_cyc_rdy),
      .bus_err       (bus_err),
      .data_core_out (data_core_out)
   );

endmodule

`default_nettype wire

// File: design/cycle_timer.sv
/*
 * Bus cycle timer
 * Steps a bus cycle through slices S0 to S7, one slice per clock,
 * holds in S4 until the slave acknowledges or signals a bus error,
 * and keeps a bus error seen in S4 to S6 until the cycle ends
 */
`timescale 1ns/1ns
`default_nettype none

module cycle_timer import biu_pkg::*;
(
   input  wire        clk,
   input  wire        resetn,
   input  bus_req_t   req,
   input  arb_state_t arb_state,
   input  wire        dtackn,
   input  wire        berrn,
   output slice_t     slice,
   output logic       berr_seen
);

   logic   req_active;
   logic   berr_now;
   logic   berr_q;
   slice_t slice_next;

   assign req_active = req.rd_bus | req.wr_bus;

   // Bus error counts only once the strobes are out
   assign berr_now = ~berrn & ((slice == S4) | (slice == S5) | (slice == S6));

   // Visible in the same slice it arrives, so S6 capture sees it
   assign berr_seen = berr_q | berr_now;

   // --------------------------------------------------------------------
   // Next slice
   // --------------------------------------------------------------------
   always_comb
   begin
      slice_next = slice;
      case (slice)
         S0: if (req_active) slice_next = S1;
         S1: slice_next = S2;
         S2: slice_next = S3;
         S3: slice_next = S4;
         // Wait state while neither dtackn nor berrn
         S4: if (~dtackn | ~berrn) slice_next = S5;
         S5: slice_next = S6;
         S6: slice_next = S7;
         default: slice_next = S0;
      endcase
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (~resetn)
         slice <= S0;
      else if (arb_state != ARB_IDLE)
         // Bus granted away, restart from idle afterwards
         slice <= S0;
      else
         slice <= slice_next;
   end

   // Bus error latch, dropped on the way back to S0
   always_ff @(posedge clk or negedge resetn)
   begin
      if (~resetn)
         berr_q <= 1'b0;
      else if (slice == S7)
         berr_q <= 1'b0;
      else if (berr_now)
         berr_q <= 1'b1;
   end

endmodule

`default_nettype wire

// File: design/strobe_decoder.sv
/*
 * Bus strobe decoder
 * Turns the slice and the arbitration state into the bus strobes,
 * driver enables, byte lane enables and cycle end flags, and holds
 * the read word sampled at the end of S6
 */
`timescale 1ns/1ns
`default_nettype none

module strobe_decoder import biu_pkg::*;
(
   input  wire         clk,
   input  wire         resetn,
   input  slice_t      slice,
   input  arb_state_t  arb_state,
   input  wire         berr_seen,
   input  bus_req_t    req,
   input  data_t       data_in,
   output bus_strobe_t strobes,
   output logic        bus_en,
   output logic        adr_en,
   output logic        hi_byte_en,
   output logic        lo_byte_en,
   output logic        bus_cyc_rdy,
   output logic        bus_err,
   output data_t       data_core_out
);

   logic owned;
   logic rd;
   logic wr;
   logic upper;
   logic lower;
   logic ds_act;

   // True when s lies inside the window first..last
   function automatic logic in_window(input slice_t s, input slice_t first,
                                      input slice_t last);
      return (s >= first) && (s <= last);
   endfunction

   // Control lines driven only while no other master holds the bus
   assign owned = (arb_state == ARB_IDLE);
   assign rd    = owned & req.rd_bus;
   assign wr    = owned & req.wr_bus;

   // Lane rule, even byte on the upper lane
   assign upper = req.byten_word | ~req.a0;
   assign lower = req.byten_word | req.a0;

   // --------------------------------------------------------------------
   // Strobes
   // --------------------------------------------------------------------
   assign ds_act = (rd & in_window(slice, RD_DS_FIRST, RD_DS_LAST)) |
                   (wr & in_window(slice, WR_DS_FIRST, WR_DS_LAST));

   assign strobes.asn  = ~((rd | wr) & in_window(slice, AS_FIRST, AS_LAST));
   assign strobes.udsn = ~(ds_act & upper);
   assign strobes.ldsn = ~(ds_act & lower);
   // rwn brackets the data strobes on both sides
   assign strobes.rwn  = ~(wr & in_window(slice, RW_FIRST, RW_LAST));

   // Three-state enable for as, uds, lds and rw together
   assign bus_en = owned;
   assign adr_en = owned & in_window(slice, ADR_FIRST, ADR_LAST);

   // Data drivers for writes only
   assign hi_byte_en = wr & upper & in_window(slice, LANE_FIRST, LANE_LAST);
   assign lo_byte_en = wr & lower & in_window(slice, LANE_FIRST, LANE_LAST);

   // --------------------------------------------------------------------
   // Cycle end
   // --------------------------------------------------------------------
   assign bus_cyc_rdy = owned & (slice == RDY_SLICE);
   assign bus_err     = bus_cyc_rdy & berr_seen;

   // Read word, kept as it was after a bus error
   always_ff @(posedge clk or negedge resetn)
   begin
      if (~resetn)
         data_core_out <= '0;
      else if (rd && (slice == CAP_SLICE) && !berr_seen)
         data_core_out <= data_in;
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus interface testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module bus_interface_tb \
   -o sim_bus_interface

# Assertion errors must not stop the model before the testbench reports them
./obj_dir/sim_bus_interface +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
   exit 1
fi
if ! grep -q "Everything OK" sim.log; then
   exit 1
fi
exit 0

// File: sim.f
common/biu_pkg.sv
design/cycle_timer.sv
design/bus_arbiter.sv
design/strobe_decoder.sv
design/bus_interface.sv
bench/bus_interface_props.sv
bench/bus_interface_tb.sv
